/* hw/snoop_cfg.svh */
`ifndef SNOOP_CFG_SVH
`define SNOOP_CFG_SVH

// Cache ports taking part in the snoop
`define SNOOP_NUM_PORTS  4

// One R or CD beat, half a line
`define SNOOP_DATA_W     64
`define SNOOP_ADDR_W     32
`define SNOOP_ID_W       4

`define SNOOP_REQ_DEPTH  2
`define SNOOP_DATA_DEPTH 2

`endif

/* hw/snoop_pkg.sv */
`include "snoop_cfg.svh"

package snoop_pkg;

    // Outcome of the snoop phase
    typedef enum logic {
        SEND_INVALID_ACK_R,
        READ_SNP_DATA
    } su_op_e;

    // Queued read request, stays at the queue head until its response is done
    typedef struct packed {
        logic [`SNOOP_ADDR_W-1:0] addr;
        logic [`SNOOP_ID_W-1:0]   id;
        logic                     single_beat;
    } snoop_req_t;

endpackage

/* hw/beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = 2
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic push_i,
    input  T     data_i,
    output logic full_o,
    input  logic pop_i,
    output T     data_o,
    output logic empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];  // Head entry, no fall-through

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_i && full_o) && !(pop_i && empty_o))
        else $error("beat_fifo overflow or underflow");

endmodule

/* hw/snoop_resp_collector.sv */
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_resp_collector (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 start_i,
    input  logic [`SNOOP_ADDR_W-1:0]             addr_i,
    output logic [`SNOOP_NUM_PORTS-1:0]          ac_valid_o,
    input  logic [`SNOOP_NUM_PORTS-1:0]          ac_ready_i,
    output logic [`SNOOP_ADDR_W-1:0]             ac_addr_o,
    input  logic [`SNOOP_NUM_PORTS-1:0]          cr_valid_i,
    output logic [`SNOOP_NUM_PORTS-1:0]          cr_ready_o,
    input  logic [`SNOOP_NUM_PORTS-1:0][2:0]     cr_resp_i,  // {dirty, shared, data}
    output logic                                 result_valid_o,
    output logic [`SNOOP_NUM_PORTS-1:0]          data_mask_o,
    output logic [$clog2(`SNOOP_NUM_PORTS)-1:0]  first_idx_o,
    output logic                                 shared_o,
    output logic                                 dirty_o,
    output snoop_pkg::su_op_e                    op_o
);
    import snoop_pkg::*;

    localparam int unsigned N     = `SNOOP_NUM_PORTS;
    localparam int unsigned IDX_W = $clog2(N);

    logic                     busy_q;
    logic [N-1:0]             ac_pend_q;
    logic [N-1:0]             cr_got_q;
    logic [N-1:0][2:0]        resp_q;
    logic [N-1:0][2:0]        resp_d;
    logic [N-1:0]             cr_fire;
    logic [N-1:0]             mask;
    logic [`SNOOP_ADDR_W-1:0] addr_q;

    assign ac_valid_o     = ac_pend_q;
    assign ac_addr_o      = addr_q;
    assign cr_ready_o     = {N{busy_q}};
    assign cr_fire        = cr_valid_i & cr_ready_o;
    assign result_valid_o = busy_q && ((cr_got_q | cr_fire) == '1);

    // Mask hidden until every port has answered, so first_idx cannot move
    assign data_mask_o = (busy_q && !result_valid_o) ? '0 : mask;
    assign op_o        = (mask != '0) ? READ_SNP_DATA : SEND_INVALID_ACK_R;

    always_comb begin
        shared_o    = 1'b0;
        dirty_o     = 1'b0;
        first_idx_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            resp_d[i] = cr_fire[i] ? cr_resp_i[i] : resp_q[i];
            mask[i]   = resp_d[i][0];
            shared_o  = shared_o | resp_d[i][1];
            dirty_o   = dirty_o | resp_d[i][2];
            if (mask[i]) begin
                first_idx_o = IDX_W'(i);  // Lowest index wins
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            ac_pend_q <= '0;
            cr_got_q  <= '0;
            resp_q    <= '0;
        end else if (start_i) begin
            busy_q    <= 1'b1;
            ac_pend_q <= '1;  // Broadcast to all ports
            cr_got_q  <= '0;
            resp_q    <= '0;
        end else begin
            ac_pend_q <= ac_pend_q & ~ac_ready_i;
            cr_got_q  <= cr_got_q | cr_fire;
            resp_q    <= resp_d;
            if (result_valid_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q <= addr_i;
        end
    end

    // A port answers only after its own AC handshake
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        busy_q |-> ((cr_valid_i & ac_pend_q) == '0))
        else $error("CR before AC handshake, pending %h", ac_pend_q);

endmodule

/* hw/snoop_data_collector.sv */
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_data_collector (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic [`SNOOP_NUM_PORTS-1:0]              cd_valid_i,
    output logic [`SNOOP_NUM_PORTS-1:0]              cd_ready_o,
    input  logic [`SNOOP_NUM_PORTS-1:0][`SNOOP_DATA_W-1:0] cd_data_i,
    input  logic [`SNOOP_NUM_PORTS-1:0]              cd_last_i,
    input  logic [`SNOOP_NUM_PORTS-1:0]              data_mask_i,
    input  logic [$clog2(`SNOOP_NUM_PORTS)-1:0]      first_idx_i,
    input  logic                                     fifo_full_i,
    input  logic                                     done_i,
    output logic                                     push_o,
    output logic [`SNOOP_DATA_W-1:0]                 push_data_o,
    output logic                                     all_last_o
);

    logic [`SNOOP_NUM_PORTS-1:0] last_q;

    always_comb begin
        cd_ready_o = data_mask_i & ~last_q;
        if (fifo_full_i) begin
            cd_ready_o[first_idx_i] = 1'b0;  // Back-pressure from R
        end
    end

    // Only the first responder feeds the queue, others are drained
    assign push_o      = cd_valid_i[first_idx_i] && cd_ready_o[first_idx_i];
    assign push_data_o = cd_data_i[first_idx_i];
    assign all_last_o  = ((last_q & data_mask_i) == data_mask_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (done_i) begin
            last_q <= '0;
        end else begin
            last_q <= last_q | (cd_valid_i & cd_ready_o & cd_last_i);
        end
    end

    // Control must not retire a request while a port still owes data
    assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> all_last_o)
        else $error("done with last beats outstanding, mask %h last %h",
                    data_mask_i, last_q);

endmodule

/* hw/snoop_ctrl.sv */
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     req_empty_i,
    input  snoop_pkg::snoop_req_t    req_i,
    output logic                     req_pop_o,
    output logic                     start_o,
    output logic [`SNOOP_ADDR_W-1:0] addr_o,
    output logic                     done_o,
    input  logic                     result_valid_i,
    input  snoop_pkg::su_op_e        op_i,
    input  logic                     shared_i,
    input  logic                     dirty_i,
    input  logic                     data_empty_i,
    input  logic [`SNOOP_DATA_W-1:0] data_i,
    output logic                     data_pop_o,
    input  logic                     all_last_i,
    output logic                     r_valid_o,
    input  logic                     r_ready_i,
    output logic [`SNOOP_DATA_W-1:0] r_data_o,
    output logic [`SNOOP_ID_W-1:0]   r_id_o,
    output logic                     r_last_o,
    output logic                     r_shared_o,
    output logic                     r_dirty_o
);
    import snoop_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SNOOP,
        SEND_LO,
        SEND_HI,
        WAIT_R,
        WAIT_LAST
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   start_q;
    logic   inv_ack;

    assign start_o   = start_q;
    assign addr_o    = req_i.addr;
    assign r_id_o    = req_i.id;  // Head is popped only with done
    assign req_pop_o = done_o;
    assign inv_ack   = (state_q == WAIT_R) ||
                       (state_q == SNOOP && result_valid_i && op_i == SEND_INVALID_ACK_R);

    always_comb begin
        state_d    = state_q;
        done_o     = 1'b0;
        data_pop_o = 1'b0;
        r_valid_o  = 1'b0;
        r_last_o   = 1'b0;
        r_data_o   = data_i;
        r_shared_o = shared_i;
        r_dirty_o  = dirty_i;
        case (state_q)
            IDLE: begin
                if (!req_empty_i) begin
                    state_d = SNOOP;
                end
            end
            SNOOP: begin
                if (result_valid_i && op_i == READ_SNP_DATA) begin
                    state_d = SEND_LO;
                end
            end
            SEND_LO: begin
                if (!data_empty_i) begin
                    if (req_i.single_beat && req_i.addr[3]) begin
                        data_pop_o = 1'b1;  // Lower word not wanted
                        state_d    = SEND_HI;
                    end else begin
                        r_valid_o = 1'b1;
                        r_last_o  = req_i.single_beat;
                        if (r_ready_i) begin
                            data_pop_o = 1'b1;
                            state_d    = req_i.single_beat ? WAIT_LAST : SEND_HI;
                        end
                    end
                end
            end
            SEND_HI: begin
                r_last_o = 1'b1;
                if (!data_empty_i) begin
                    r_valid_o = 1'b1;
                    if (r_ready_i) begin
                        data_pop_o = 1'b1;
                        done_o     = all_last_i;
                        state_d    = all_last_i ? IDLE : WAIT_LAST;
                    end
                end
            end
            WAIT_LAST: begin
                data_pop_o = !data_empty_i;  // Drain unused upper word
                if (all_last_i && data_empty_i) begin
                    done_o  = 1'b1;
                    state_d = IDLE;
                end
            end
            default: ;
        endcase

        // Invalid ack, one zero beat with last
        if (inv_ack) begin
            r_valid_o  = 1'b1;
            r_last_o   = 1'b1;
            r_data_o   = '0;
            r_shared_o = 1'b0;
            r_dirty_o  = 1'b0;
            done_o     = r_ready_i;
            state_d    = r_ready_i ? IDLE : WAIT_R;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= (state_q == IDLE) && !req_empty_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o &&
            $stable({r_data_o, r_id_o, r_last_o, r_shared_o, r_dirty_o}))
        else $error("R changed under back-pressure, data %h", r_data_o);

endmodule

/* hw/snoop_unit_top.sv */
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_unit_top (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     wb_cyc_i,
    input  logic                                     wb_stb_i,
    input  logic                                     wb_we_i,
    input  logic [`SNOOP_ADDR_W-1:0]                 wb_adr_i,
    input  logic [31:0]                              wb_dat_i,  // {.., single, id}
    output logic                                     wb_ack_o,
    output logic [`SNOOP_NUM_PORTS-1:0]              ac_valid_o,
    input  logic [`SNOOP_NUM_PORTS-1:0]              ac_ready_i,
    output logic [`SNOOP_ADDR_W-1:0]                 ac_addr_o,
    input  logic [`SNOOP_NUM_PORTS-1:0]              cr_valid_i,
    output logic [`SNOOP_NUM_PORTS-1:0]              cr_ready_o,
    input  logic [`SNOOP_NUM_PORTS-1:0][2:0]         cr_resp_i,
    input  logic [`SNOOP_NUM_PORTS-1:0]              cd_valid_i,
    output logic [`SNOOP_NUM_PORTS-1:0]              cd_ready_o,
    input  logic [`SNOOP_NUM_PORTS-1:0][`SNOOP_DATA_W-1:0] cd_data_i,
    input  logic [`SNOOP_NUM_PORTS-1:0]              cd_last_i,
    output logic                                     r_valid_o,
    input  logic                                     r_ready_i,
    output logic [`SNOOP_DATA_W-1:0]                 r_data_o,
    output logic [`SNOOP_ID_W-1:0]                   r_id_o,
    output logic                                     r_last_o,
    output logic                                     r_shared_o,
    output logic                                     r_dirty_o
);
    import snoop_pkg::*;

    logic                                wb_req;
    logic                                wb_ack_q;
    snoop_req_t                          req_in;
    snoop_req_t                          req_head;
    logic                                req_push;
    logic                                req_pop;
    logic                                req_full;
    logic                                req_empty;
    logic                                start;
    logic [`SNOOP_ADDR_W-1:0]            snoop_addr;
    logic                                result_valid;
    logic [`SNOOP_NUM_PORTS-1:0]         data_mask;
    logic [$clog2(`SNOOP_NUM_PORTS)-1:0] first_idx;
    logic                                shared;
    logic                                dirty;
    su_op_e                              op;
    logic                                done;
    logic                                all_last;
    logic                                data_push;
    logic                                data_pop;
    logic                                data_full;
    logic                                data_empty;
    logic [`SNOOP_DATA_W-1:0]            data_in;
    logic [`SNOOP_DATA_W-1:0]            data_head;

    // Wishbone classic entry, ack one cycle after strobe
    assign wb_req   = wb_cyc_i && wb_stb_i && !wb_ack_q;
    assign req_push = wb_req && wb_we_i && !req_full;
    assign wb_ack_o = wb_ack_q;
    assign req_in   = '{addr: wb_adr_i, id: wb_dat_i[`SNOOP_ID_W-1:0], single_beat: wb_dat_i[4]};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_ack_q <= 1'b0;
        end else begin
            wb_ack_q <= wb_req && (!wb_we_i || !req_full);  // Full queue adds wait states
        end
    end

    beat_fifo #(
        .T     (snoop_req_t),
        .DEPTH (`SNOOP_REQ_DEPTH)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (req_push),
        .data_i  (req_in),
        .full_o  (req_full),
        .pop_i   (req_pop),
        .data_o  (req_head),
        .empty_o (req_empty)
    );

    snoop_resp_collector u_resp (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start),
        .addr_i         (snoop_addr),
        .ac_valid_o     (ac_valid_o),
        .ac_ready_i     (ac_ready_i),
        .ac_addr_o      (ac_addr_o),
        .cr_valid_i     (cr_valid_i),
        .cr_ready_o     (cr_ready_o),
        .cr_resp_i      (cr_resp_i),
        .result_valid_o (result_valid),
        .data_mask_o    (data_mask),
        .first_idx_o    (first_idx),
        .shared_o       (shared),
        .dirty_o        (dirty),
        .op_o           (op)
    );

    snoop_data_collector u_data (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cd_valid_i  (cd_valid_i),
        .cd_ready_o  (cd_ready_o),
        .cd_data_i   (cd_data_i),
        .cd_last_i   (cd_last_i),
        .data_mask_i (data_mask),
        .first_idx_i (first_idx),
        .fifo_full_i (data_full),
        .done_i      (done),
        .push_o      (data_push),
        .push_data_o (data_in),
        .all_last_o  (all_last)
    );

    beat_fifo #(
        .T     (logic [`SNOOP_DATA_W-1:0]),
        .DEPTH (`SNOOP_DATA_DEPTH)
    ) u_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (data_push),
        .data_i  (data_in),
        .full_o  (data_full),
        .pop_i   (data_pop),
        .data_o  (data_head),
        .empty_o (data_empty)
    );

    snoop_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_empty_i    (req_empty),
        .req_i          (req_head),
        .req_pop_o      (req_pop),
        .start_o        (start),
        .addr_o         (snoop_addr),
        .done_o         (done),
        .result_valid_i (result_valid),
        .op_i           (op),
        .shared_i       (shared),
        .dirty_i        (dirty),
        .data_empty_i   (data_empty),
        .data_i         (data_head),
        .data_pop_o     (data_pop),
        .all_last_i     (all_last),
        .r_valid_o      (r_valid_o),
        .r_ready_i      (r_ready_i),
        .r_data_o       (r_data_o),
        .r_id_o         (r_id_o),
        .r_last_o       (r_last_o),
        .r_shared_o     (r_shared_o),
        .r_dirty_o      (r_dirty_o)
    );

endmodule

/* testbench/tb_snoop_unit.sv */
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module tb_snoop_unit;

    localparam int N       = `SNOOP_NUM_PORTS;
    localparam int TIMEOUT = 2000;  // Cycles per wait

    logic                          clk_i;
    logic                          rst_ni;
    logic                          wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [`SNOOP_ADDR_W-1:0]      wb_adr_i;
    logic [31:0]                   wb_dat_i;
    logic [N-1:0]                  ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    logic [`SNOOP_ADDR_W-1:0]      ac_addr_o;
    logic [N-1:0][2:0]             cr_resp_i;  // {dirty, shared, data}
    logic [N-1:0]                  cd_valid_i, cd_ready_o, cd_last_i;
    logic [N-1:0][`SNOOP_DATA_W-1:0] cd_data_i;
    logic                          r_valid_o, r_ready_i, r_last_o, r_shared_o, r_dirty_o;
    logic [`SNOOP_DATA_W-1:0]      r_data_o;
    logic [`SNOOP_ID_W-1:0]        r_id_o;

    logic [15:0]  lfsr;
    logic [2:0]   flags_mem [32][N];
    logic [3:0]   id_mem [32];
    logic [31:0]  addr_mem [32];
    int           ac_cnt [N];
    int           cur_req [N];
    logic [N-1:0] cr_pend, cd_busy, cd_beat, cd_held, snoop_mask;
    logic [N-1:0] ac_rnd;
    logic [N-1:0] cd_rnd;
    logic         r_rnd;
    logic [70:0]  exp_q [$];
    logic [70:0]  exp_head;  // {id, last, shared, dirty, data}
    int           exp_cnt, req_cnt, errors, test_num, tests_ok;
    logic         bp_mode;

    snoop_unit_top dut (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // Port model payload tagged with port, beat and id
    function automatic logic [63:0] cd_word(input int p, input logic beat, input logic [3:0] id);
        return {16'hC0DE, 8'(p), 7'd0, beat, 28'd0, id};
    endfunction

    function void refresh_head();
        exp_cnt  = exp_q.size();
        exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
    endfunction

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
        int   cnt;
        logic acked;
        cnt      = 0;
        acked    = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        while (!acked && cnt < TIMEOUT) begin
            @(posedge clk_i);
            acked = wb_ack_o;
            cnt++;
        end
        #2;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!acked) begin
            errors++;
            $display("Timeout: no Wishbone ack for request at %h", adr);
        end
    endtask

    // Draws the port flags, queues the expected R beats, then enters the request
    task automatic issue_req(input logic single, input logic addr3, input logic no_data);
        logic [N-1:0] mask;
        logic         sh;
        logic         dt;
        int           first;
        logic [3:0]   id;
        logic [31:0]  addr;
        mask  = '0;
        sh    = 1'b0;
        dt    = 1'b0;
        first = 0;
        id    = 4'(req_cnt);
        addr  = 32'h4000_0000 | (32'(req_cnt) << 6) | {28'd0, addr3, 3'd0};
        for (int p = N - 1; p >= 0; p--) begin
            flags_mem[req_cnt][p] = {rand_bit(), rand_bit(), rand_bit() && !no_data};
            if (p == N - 1 && !no_data) begin
                flags_mem[req_cnt][p][0] = 1'b1;  // At least one owner
            end
            mask[p] = flags_mem[req_cnt][p][0];
            sh      = sh | flags_mem[req_cnt][p][1];
            dt      = dt | flags_mem[req_cnt][p][2];
            if (mask[p]) begin
                first = p;
            end
        end
        id_mem[req_cnt]   = id;
        addr_mem[req_cnt] = addr;
        if (mask == '0) begin
            exp_q.push_back({id, 3'b100, 64'd0});
        end else if (single) begin
            exp_q.push_back({id, 1'b1, sh, dt, cd_word(first, addr3, id)});
        end else begin
            exp_q.push_back({id, 1'b0, sh, dt, cd_word(first, 1'b0, id)});
            exp_q.push_back({id, 1'b1, sh, dt, cd_word(first, 1'b1, id)});
        end
        refresh_head();
        wb_write(addr, {27'd0, single, id});
        req_cnt++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk_i);
            #1;
            cnt++;
        end while ((exp_cnt != 0 || cr_pend != '0 || cd_busy != '0) && cnt < TIMEOUT);
        #1;
        if (cnt >= TIMEOUT) begin
            errors++;
            $display("Timeout: responses still outstanding in test %s", name);
        end
        test_num++;
        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - err_before);
        end
    endtask

    // Cache ports and R sink, sampled at the edge and driven 2 ns later
    always @(posedge clk_i) begin
        if (rst_ni) begin
            for (int p = 0; p < N; p++) begin
                cd_held[p] = cd_valid_i[p] && !cd_ready_o[p];
                if (ac_valid_o[p] && ac_ready_i[p]) begin
                    cur_req[p] = ac_cnt[p];
                    ac_cnt[p]++;
                    cr_pend[p] = 1'b1;
                    if (p == 0) begin
                        for (int q = 0; q < N; q++) begin
                            snoop_mask[q] = flags_mem[cur_req[0]][q][0];
                        end
                    end
                end
                if (cr_valid_i[p] && cr_ready_o[p]) begin
                    cr_pend[p] = 1'b0;
                    cd_busy[p] = flags_mem[cur_req[p]][p][0];
                    cd_beat[p] = 1'b0;
                end
                if (cd_valid_i[p] && cd_ready_o[p]) begin
                    cd_busy[p] = !cd_last_i[p];
                    cd_beat[p] = 1'b1;
                end
            end
            if (r_valid_o && r_ready_i && exp_cnt > 0) begin
                void'(exp_q.pop_front());
                refresh_head();
            end
            // Stall choices for the next cycle
            for (int p = 0; p < N; p++) begin
                ac_rnd[p] = rand_bit();
                cd_rnd[p] = cd_busy[p] && !cd_held[p] && rand_bit();
            end
            r_rnd = !bp_mode || rand_bit();
            #2;
            for (int p = 0; p < N; p++) begin
                ac_ready_i[p] = ac_rnd[p];
                cr_valid_i[p] = cr_pend[p];
                cr_resp_i[p]  = flags_mem[cur_req[p]][p];
                cd_valid_i[p] = cd_busy[p] && (cd_held[p] || cd_rnd[p]);  // Hold until taken
                cd_data_i[p]  = cd_word(p, cd_beat[p], id_mem[cur_req[p]]);
                cd_last_i[p]  = cd_beat[p];
            end
            r_ready_i = r_rnd;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ac_valid_o[0] |-> ac_addr_o == addr_mem[ac_cnt[0]])
        else begin
            errors++;
            $display("Error: ac_addr_o %h, expected %h",
                     $sampled(ac_addr_o), $sampled(addr_mem[ac_cnt[0]]));
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && r_ready_i |-> exp_cnt > 0)
        else begin
            errors++;
            $display("R beat returned with no response expected, data %h", $sampled(r_data_o));
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && r_ready_i && exp_cnt > 0 |-> r_data_o == exp_head[63:0])
        else begin
            errors++;
            $display("Error: r_data_o %h, expected %h",
                     $sampled(r_data_o), $sampled(exp_head[63:0]));
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && r_ready_i && exp_cnt > 0 |-> r_id_o == exp_head[70:67])
        else begin
            errors++;
            $display("Error: r_id_o %h, expected %h", $sampled(r_id_o), $sampled(exp_head[70:67]));
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && r_ready_i && exp_cnt > 0 |->
            {r_last_o, r_shared_o, r_dirty_o} == exp_head[66:64])
        else begin
            errors++;
            $display("Error: r_last_o,r_shared_o,r_dirty_o %h, expected %h",
                     $sampled({r_last_o, r_shared_o, r_dirty_o}), $sampled(exp_head[66:64]));
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o &&
            $stable({r_data_o, r_id_o, r_last_o, r_shared_o, r_dirty_o}))
        else begin
            errors++;
            $display("R beat changed or was withdrawn while stalled");
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) (cd_ready_o & ~snoop_mask) == '0)
        else begin
            errors++;
            $display("Error: cd_ready_o %h outside data mask %h",
                     $sampled(cd_ready_o), $sampled(snoop_mask));
        end

    // Next snoop only once every owner has delivered its last beat
    assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(ac_valid_o[0]) |-> cd_busy == '0)
        else begin
            errors++;
            $display("Snoop started while ports still owed CD data, ports %h", $sampled(cd_busy));
        end

    initial begin
        int err0;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        ac_ready_i = '0;
        cr_valid_i = '0;
        cr_resp_i  = '0;
        cd_valid_i = '0;
        cd_data_i  = '0;
        cd_last_i  = '0;
        r_ready_i  = 1'b0;
        lfsr       = 16'd78;
        cr_pend    = '0;
        cd_busy    = '0;
        cd_beat    = '0;
        snoop_mask = '0;
        bp_mode    = 1'b0;
        refresh_head();
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        err0 = errors;
        issue_req(1'b0, 1'b0, 1'b1);
        finish_test("no data offered", err0);
        err0 = errors;
        issue_req(1'b0, 1'b0, 1'b0);
        finish_test("full line", err0);
        err0 = errors;
        issue_req(1'b1, 1'b0, 1'b0);
        issue_req(1'b1, 1'b1, 1'b0);
        finish_test("single beat", err0);
        err0    = errors;
        bp_mode = 1'b1;
        for (int i = 0; i < 3; i++) begin
            issue_req(1'b0, 1'b0, 1'b0);
        end
        finish_test("R back-pressure", err0);
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            issue_req(i[0], i[1], i == 2);  // Mixed sizes, one miss
        end
        finish_test("back to back", err0);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_num, tests_ok, test_num - tests_ok, errors);
        if (errors == 0 && tests_ok == test_num) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/snoop_pkg.sv
hw/beat_fifo.sv
hw/snoop_resp_collector.sv
hw/snoop_data_collector.sv
hw/snoop_ctrl.sv
hw/snoop_unit_top.sv
testbench/tb_snoop_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the snoop unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_snoop_unit -o tb_snoop_unit
./obj_dir/tb_snoop_unit | tee sim.log
grep -q "TEST PASSED" sim.log
